// File: verilog/vdma_geom_pkg.sv
// video frame writer geometry definitions
// pixel and word widths, byte addresses, line counts
// and the pixel-word union shared by the packer, the FIFO and the AXI master

package vdma_geom_pkg;

    // one pixel per video clock
    localparam int PIX_W        = 32;
    localparam int PIX_PER_WORD = 4;

    // AXI data beat
    localparam int WORD_W         = PIX_W * PIX_PER_WORD;
    localparam int BYTES_PER_WORD = WORD_W / 8;

    // byte address into memory
    localparam int ADDR_W = 32;

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // pixels per active line
    typedef logic [15:0] hcount_t;

    // one AXI word, filled by pixel slot or moved as a flat vector
    // pixel 0 sits in the low slot
    typedef union packed {
        pixel_t [PIX_PER_WORD-1:0] pix;
        logic [WORD_W-1:0]         raw;
    } axi_word_u;

endpackage

// File: verilog/axi_wr_pkg.sv
// AXI4 write channel encodings
// burst type, beat size and burst length widths used by the write engine

package axi_wr_pkg;

    // awburst codes
    localparam logic [1:0] BURST_INCR = 2'b01;

    // awsize codes, log2 of bytes per beat
    localparam logic [2:0] SIZE_16B = 3'b100;

    // awlen field width, AXI4 allows up to 256 beats
    localparam int AXI_LEN_W = 8;

    // burst length in beats, wide enough to hold 256
    typedef logic [AXI_LEN_W:0] burst_len_t;

endpackage

// File: verilog/pixel_packer.sv
// video pixel packer
// finds frame start on vsync and line end on falling de,
// packs four pixels into one AXI word, zero-pads the last word of a line

`timescale 1ns/10ps

module pixel_packer import vdma_geom_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      vsync,
    input  logic      de,
    input  pixel_t    idata,
    output logic      frame_start,
    output logic      push,
    output axi_word_u push_word
);

    localparam int SLOT_W = $clog2(PIX_PER_WORD);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(PIX_PER_WORD - 1);

    logic              vsync_d;
    logic              de_d;
    logic              vsync_rise;
    logic              line_end;
    logic [SLOT_W-1:0] slot;
    axi_word_u         acc;
    axi_word_u         nxt;

    // edge detect against last sample
    assign vsync_rise = vsync && !vsync_d;
    assign line_end   = !de && de_d;

    // partial word with the incoming pixel placed
    // a fresh word starts from zero so unused slots stay clear
    always_comb begin
        nxt = acc;
        if (slot == '0) begin
            nxt = '0;
        end
        nxt.pix[slot] = idata;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vsync_d     <= 1'b0;
            de_d        <= 1'b0;
            frame_start <= 1'b0;
            push        <= 1'b0;
            slot        <= '0;
        end else begin
            vsync_d     <= vsync;
            de_d        <= de;
            frame_start <= vsync_rise;
            push        <= 1'b0;
            if (vsync_rise) begin
                // new frame drops any half-built word
                slot <= '0;
            end else if (de) begin
                // counter wraps after the last slot
                push <= (slot == LAST_SLOT);
                slot <= slot + 1'b1;
            end else if (line_end && slot != '0) begin
                // flush the tail of the line
                push <= 1'b1;
                slot <= '0;
            end
        end
    end

    // word data
    always_ff @(posedge clock) begin
        if (vsync_rise) begin
            acc <= '0;
        end else if (de) begin
            acc <= nxt;
            if (slot == LAST_SLOT) begin
                push_word <= nxt;
            end
        end else if (line_end) begin
            push_word <= acc;
        end
    end

endmodule

// File: verilog/line_fifo.sv
// line buffer FIFO
// single clock, first word falls through to the head,
// fill level and almost-full flag for the burst scheduler and the source

`timescale 1ns/10ps

module line_fifo import vdma_geom_pkg::*; #(
    parameter int FIFO_DEPTH   = 64,
    parameter int AFULL_MARGIN = 4
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        clear,
    input  logic                        push,
    input  axi_word_u                   push_word,
    input  logic                        pop,
    output axi_word_u                   head_word,
    output logic                        empty,
    output logic [$clog2(FIFO_DEPTH):0] level,
    output logic                        almost_full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              wr_en;
    logic              rd_en;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // clear wins over both ports
    assign wr_en = push && !full && !clear;
    assign rd_en = pop && !empty && !clear;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on the power-of-two depth
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_word.raw;
        end
    end

    // head is visible the cycle after the write
    assign head_word.raw = mem[rd_ptr];
    assign level         = count;

    // free space down to the margin
    assign almost_full = ((CNT_W'(FIFO_DEPTH) - count) <= CNT_W'(AFULL_MARGIN));

    // source must honour almost_full, an overflow loses a word
    a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
        push |-> !full)
        else $error("line_fifo: push while full, word lost");

    // master only reads what the scheduler saw in the level
    a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n)
        pop |-> !empty)
        else $error("line_fifo: pop while empty");

endmodule

// File: verilog/burst_scheduler.sv
// burst scheduler
// splits each active line into full bursts and one shorter tail burst,
// requests a burst once the FIFO holds enough words for it,
// and tracks the memory address of every burst and line

`timescale 1ns/10ps

module burst_scheduler import vdma_geom_pkg::*; import axi_wr_pkg::*; #(
    parameter int BURST_LEN   = 16,
    parameter int LINE_STRIDE = 8192,
    parameter int FIFO_DEPTH  = 64
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        enable,
    input  logic                        frame_start,
    input  addr_t                       baseaddr,
    input  hcount_t                     hactive,
    input  logic [$clog2(FIFO_DEPTH):0] level,
    input  logic                        done,
    output logic                        req,
    output burst_len_t                  req_len,
    output addr_t                       req_addr
);

    hcount_t words_per_line;
    hcount_t line_words;
    hcount_t words_left;
    hcount_t cur_len;
    addr_t   line_addr;
    addr_t   next_line;
    addr_t   burst_bytes;
    logic    line_done;

    // words per line, rounded up for a padded tail word
    assign words_per_line = hcount_t'(({1'b0, hactive} + PIX_PER_WORD - 1) / PIX_PER_WORD);

    // full burst, or what is left of the line
    assign cur_len   = (words_left < hcount_t'(BURST_LEN)) ? words_left : hcount_t'(BURST_LEN);
    assign req_len   = burst_len_t'(cur_len);
    assign line_done = (words_left == cur_len);

    assign next_line   = line_addr + addr_t'(LINE_STRIDE);
    assign burst_bytes = addr_t'(cur_len) * addr_t'(BYTES_PER_WORD);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            req        <= 1'b0;
            line_words <= '0;
            words_left <= '0;
            line_addr  <= '0;
            req_addr   <= '0;
        end else if (frame_start) begin
            // line 0 starts at the latched base
            req        <= 1'b0;
            line_words <= words_per_line;
            words_left <= words_per_line;
            line_addr  <= baseaddr;
            req_addr   <= baseaddr;
        end else if (done) begin
            req <= 1'b0;
            if (line_done) begin
                // step to the next line start
                line_addr  <= next_line;
                req_addr   <= next_line;
                words_left <= line_words;
            end else begin
                req_addr   <= req_addr + burst_bytes;
                words_left <= words_left - cur_len;
            end
        end else if (!req && enable && words_left != '0 && hcount_t'(level) >= cur_len) begin
            // whole burst already buffered so W never waits
            req <= 1'b1;
        end
    end

    // vsync during a burst is not handled
    a_no_frame_in_burst: assert property (@(posedge clock) disable iff (!arst_n)
        frame_start |-> !req)
        else $error("burst_scheduler: frame start while a burst is pending");

    a_len_nonzero: assert property (@(posedge clock) disable iff (!arst_n)
        req |-> req_len != '0)
        else $error("burst_scheduler: zero length request");

endmodule

// File: verilog/axi_write_master.sv
// AXI4 write master
// runs one INCR burst per request over AW, W and B,
// streams FIFO words onto W and pulses done after the write response

`timescale 1ns/10ps

module axi_write_master import vdma_geom_pkg::*; import axi_wr_pkg::*; (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 req,
    input  burst_len_t           req_len,
    input  addr_t                req_addr,
    input  axi_word_u            head_word,
    input  logic                 empty,
    output logic                 pop,
    output logic                 done,
    output addr_t                awaddr,
    output logic [AXI_LEN_W-1:0] awlen,
    output logic [2:0]           awsize,
    output logic [1:0]           awburst,
    output logic                 awvalid,
    input  logic                 awready,
    output logic [WORD_W-1:0]    wdata,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,
    output logic                 bready,
    input  logic                 bvalid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_t;

    state_t               state;
    logic [AXI_LEN_W-1:0] beat_cnt;
    logic                 start;

    // req is still high during the done cycle, skip it
    assign start = (state == S_IDLE) && req && !done;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (awready) begin
                        state    <= S_DATA;
                        beat_cnt <= '0;
                    end
                end
                S_DATA: begin
                    // count accepted beats only
                    if (wready) begin
                        if (wlast) begin
                            state <= S_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // response ignored apart from the handshake
                    if (bvalid) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // address phase fields, held for the whole burst
    always_ff @(posedge clock) begin
        if (start) begin
            awaddr <= req_addr;
            awlen  <= AXI_LEN_W'(req_len - 1'b1);
        end
    end

    assign awsize  = SIZE_16B;
    assign awburst = BURST_INCR;
    assign awvalid = (state == S_ADDR);

    assign wvalid = (state == S_DATA);
    assign wlast  = wvalid && (beat_cnt == awlen);
    assign wdata  = head_word.raw;
    assign pop    = wvalid && wready;

    assign bready = (state == S_RESP);

    // scheduler waits for a full burst in the FIFO before requesting
    a_no_starve: assert property (@(posedge clock) disable iff (!arst_n)
        wvalid |-> !empty)
        else $error("axi_write_master: W channel ran out of FIFO data");

endmodule

// File: verilog/vdma_write_top.sv
// video frame writer top level
// packer, line FIFO, burst scheduler and AXI write master on one clock,
// writes each active line to memory at base plus line index times stride

`timescale 1ns/10ps

module vdma_write_top import vdma_geom_pkg::*; import axi_wr_pkg::*; #(
    parameter int BURST_LEN    = 16,
    parameter int LINE_STRIDE  = 8192,
    parameter int FIFO_DEPTH   = 64,
    parameter int AFULL_MARGIN = 4
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 enable,
    input  addr_t                baseaddr,
    input  hcount_t              hactive,
    input  logic                 vsync,
    input  logic                 de,
    input  pixel_t               idata,
    output logic                 fifo_almost_full,
    // AXI write channels
    output addr_t                awaddr,
    output logic [AXI_LEN_W-1:0] awlen,
    output logic [2:0]           awsize,
    output logic [1:0]           awburst,
    output logic                 awvalid,
    input  logic                 awready,
    output logic [WORD_W-1:0]    wdata,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,
    output logic                 bready,
    input  logic                 bvalid
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

    logic               frame_start;
    logic               push;
    axi_word_u          push_word;
    logic               pop;
    axi_word_u          head_word;
    logic               empty;
    logic [LEVEL_W-1:0] level;
    logic               req;
    burst_len_t         req_len;
    addr_t              req_addr;
    logic               done;

    pixel_packer u_packer (
        .clock       (clock),
        .arst_n      (arst_n),
        .vsync       (vsync),
        .de          (de),
        .idata       (idata),
        .frame_start (frame_start),
        .push        (push),
        .push_word   (push_word)
    );

    // frame start flushes leftovers of the previous frame
    line_fifo #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .AFULL_MARGIN (AFULL_MARGIN)
    ) u_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .clear       (frame_start),
        .push        (push),
        .push_word   (push_word),
        .pop         (pop),
        .head_word   (head_word),
        .empty       (empty),
        .level       (level),
        .almost_full (fifo_almost_full)
    );

    burst_scheduler #(
        .BURST_LEN   (BURST_LEN),
        .LINE_STRIDE (LINE_STRIDE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_sched (
        .clock       (clock),
        .arst_n      (arst_n),
        .enable      (enable),
        .frame_start (frame_start),
        .baseaddr    (baseaddr),
        .hactive     (hactive),
        .level       (level),
        .done        (done),
        .req         (req),
        .req_len     (req_len),
        .req_addr    (req_addr)
    );

    axi_write_master u_master (
        .clock     (clock),
        .arst_n    (arst_n),
        .req       (req),
        .req_len   (req_len),
        .req_addr  (req_addr),
        .head_word (head_word),
        .empty     (empty),
        .pop       (pop),
        .done      (done),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bready    (bready),
        .bvalid    (bvalid)
    );

endmodule

// File: bench/vdma_write_tb.sv
// testbench for the video frame writer
// drives frames and lines of counting pixels, answers AXI writes with a
// randomly stalling slave, and checks every burst and beat against a model

`timescale 1ns/10ps

module vdma_write_tb import vdma_geom_pkg::*; ();

    localparam int BURST_LEN    = 4;
    localparam int LINE_STRIDE  = 256;
    localparam int FIFO_DEPTH   = 16;
    localparam int AFULL_MARGIN = 4;
    localparam int WORD_BYTES   = 16;
    localparam int WAIT_LIMIT   = 2000;

    logic              clock = 1'b0;
    logic              arst_n;
    logic              enable;
    addr_t             baseaddr;
    hcount_t           hactive;
    logic              vsync;
    logic              de;
    pixel_t            idata;
    logic              fifo_almost_full;
    addr_t             awaddr;
    logic [7:0]        awlen;
    logic [2:0]        awsize;
    logic [1:0]        awburst;
    logic              awvalid;
    logic              awready = 1'b0;
    logic [WORD_W-1:0] wdata;
    logic              wlast;
    logic              wvalid;
    logic              wready = 1'b0;
    logic              bready;
    logic              bvalid = 1'b0;

    // reference model queues filled ahead of the DUT
    addr_t             exp_addr_q[$];
    int                exp_len_q[$];
    logic [WORD_W-1:0] exp_word_q[$];
    addr_t             frame_base;
    int                frame_hact;
    int                line_idx;
    pixel_t            pix_cnt;

    // monitor state
    addr_t             mon_addr;
    int                mon_len;
    logic [WORD_W-1:0] mon_word;
    int                burst_len = 0;
    int                beat = 0;
    int                b_pend = 0;

    // slave mode 0 always ready, 1 random, 2 stalled
    int                bp_mode = 0;
    logic              quiet = 1'b0;
    integer            seed = 62057;
    logic [31:0]       rnd;

    int                errors = 0;
    int                chk_errors = 0;
    int                err_mark;
    int                tests = 0;
    int                fails = 0;
    string             cur_test = "none";

    vdma_write_top #(
        .BURST_LEN    (BURST_LEN),
        .LINE_STRIDE  (LINE_STRIDE),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .AFULL_MARGIN (AFULL_MARGIN)
    ) UUT (
        .clock            (clock),
        .arst_n           (arst_n),
        .enable           (enable),
        .baseaddr         (baseaddr),
        .hactive          (hactive),
        .vsync            (vsync),
        .de               (de),
        .idata            (idata),
        .fifo_almost_full (fifo_almost_full),
        .awaddr           (awaddr),
        .awlen            (awlen),
        .awsize           (awsize),
        .awburst          (awburst),
        .awvalid          (awvalid),
        .awready          (awready),
        .wdata            (wdata),
        .wlast            (wlast),
        .wvalid           (wvalid),
        .wready           (wready),
        .bready           (bready),
        .bvalid           (bvalid)
    );

    always #5 clock = ~clock;

    function automatic void show_mismatch(string what, logic [WORD_W-1:0] exp_v,
                                          logic [WORD_W-1:0] act_v);
        $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
    endfunction

    // AXI slave drives ready and response on the falling edge
    always @(negedge clock) begin
        rnd = $random(seed);
        case (bp_mode)
            0: begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            1: begin
                awready <= rnd[0];
                wready  <= rnd[1] | rnd[2];
            end
            default: begin
                awready <= 1'b0;
                wready  <= 1'b0;
            end
        endcase
        // once raised, bvalid holds until bready
        bvalid <= (b_pend != 0) && (bvalid || rnd[3] || bp_mode == 0);
    end

    // compare every handshake against the model
    always @(posedge clock) begin
        if (arst_n) begin
            if (awvalid && awready) begin
                if (exp_addr_q.size() == 0) begin
                    $display("%s: AW handshake with no burst expected", cur_test);
                    errors++;
                end else begin
                    mon_addr = exp_addr_q.pop_front();
                    mon_len  = exp_len_q.pop_front();
                    assert (awaddr == mon_addr) else begin
                        show_mismatch("awaddr", WORD_W'(mon_addr), WORD_W'(awaddr));
                        errors++;
                    end
                    assert (awlen == 8'(mon_len - 1)) else begin
                        show_mismatch("awlen", WORD_W'(8'(mon_len - 1)), WORD_W'(awlen));
                        errors++;
                    end
                    burst_len = mon_len;
                    beat      = 0;
                end
            end
            if (wvalid && wready) begin
                if (exp_word_q.size() == 0) begin
                    $display("%s: W beat with no word expected", cur_test);
                    errors++;
                end else begin
                    mon_word = exp_word_q.pop_front();
                    assert (wdata == mon_word) else begin
                        show_mismatch("wdata", mon_word, wdata);
                        errors++;
                    end
                end
                assert (wlast == (beat == burst_len - 1)) else begin
                    show_mismatch("wlast", WORD_W'(beat == burst_len - 1), WORD_W'(wlast));
                    errors++;
                end
                beat++;
                if (wlast) begin
                    b_pend++;
                end
            end
            if (bvalid && bready) begin
                b_pend--;
            end
        end
    end

    a_aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else begin
            $display("%s: AW request dropped or changed before awready", cur_test);
            errors++;
        end

    a_w_hold: assert property (@(posedge clock) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else begin
            $display("%s: W beat dropped or changed before wready", cur_test);
            errors++;
        end

    // INCR bursts of 16-byte beats
    a_aw_codes: assert property (@(posedge clock) disable iff (!arst_n)
        awvalid |-> awsize == 3'b100 && awburst == 2'b01)
        else begin
            $display("** Error %s awsize/awburst: expected 4/1, actual %0d/%0d",
                     cur_test, awsize, awburst);
            errors++;
        end

    a_gate_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        quiet |-> !awvalid)
        else begin
            $display("%s: awvalid raised while enable is low", cur_test);
            errors++;
        end

    task automatic timeout_abort(input string what);
        $display("timeout in %s: %s", cur_test, what);
        $display("test failed");
        $finish;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors + chk_errors;
    endtask

    task automatic end_test();
        int n;
        n = errors + chk_errors - err_mark;
        tests++;
        if (n == 0) begin
            $display("[%0d] %s: ok", tests, cur_test);
        end else begin
            fails++;
            $display("[%0d] %s: FAILED with %0d errors", tests, cur_test, n);
        end
    endtask

    // vsync pulse latches base and line length
    task automatic start_frame(input addr_t base, input int hact);
        baseaddr   = base;
        hactive    = hcount_t'(hact);
        frame_base = base;
        frame_hact = hact;
        line_idx   = 0;
        vsync      = 1'b1;
        @(negedge clock);
        vsync = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    // one active line with model entries pushed before the DUT needs them
    task automatic send_line();
        logic [WORD_W-1:0] word;
        int                slot;
        int                i;
        int                nwords;
        int                offs;
        int                len;
        addr_t             line_base;
        nwords    = (frame_hact + PIX_PER_WORD - 1) / PIX_PER_WORD;
        line_base = frame_base + addr_t'(line_idx * LINE_STRIDE);
        offs      = 0;
        while (nwords > 0) begin
            len = (nwords < BURST_LEN) ? nwords : BURST_LEN;
            exp_addr_q.push_back(line_base + addr_t'(offs * WORD_BYTES));
            exp_len_q.push_back(len);
            offs   += len;
            nwords -= len;
        end
        // pixel 0 of each word in the low slot and unused slots zero
        word = '0;
        slot = 0;
        for (i = 0; i < frame_hact; i++) begin
            de    = 1'b1;
            idata = pix_cnt;
            word[slot*PIX_W +: PIX_W] = pix_cnt;
            pix_cnt++;
            slot++;
            if (slot == PIX_PER_WORD) begin
                exp_word_q.push_back(word);
                word = '0;
                slot = 0;
            end
            @(negedge clock);
        end
        if (slot != 0) begin
            exp_word_q.push_back(word);
        end
        de = 1'b0;
        line_idx++;
        repeat (4) @(negedge clock);
    endtask

    // all expected bursts written and answered
    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_word_q.size() != 0 || exp_addr_q.size() != 0 || b_pend != 0 || bready)
               && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timeout_abort("writer did not finish the expected bursts");
        end else begin
            repeat (3) @(negedge clock);
        end
    endtask

    task automatic wait_almost_full(input logic val);
        int n;
        n = 0;
        while (fifo_almost_full !== val && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timeout_abort(val ? "fifo_almost_full never rose" : "fifo_almost_full never fell");
        end
    endtask

    initial begin
        arst_n   = 1'b0;
        enable   = 1'b0;
        baseaddr = '0;
        hactive  = '0;
        vsync    = 1'b0;
        de       = 1'b0;
        idata    = '0;
        pix_cnt  = 32'h0000_0001;
        repeat (2) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);

        begin_test("reset state");
        assert (!awvalid && !wvalid && !wlast && !bready && !fifo_almost_full) else begin
            $display("%s: AXI valid, bready or almost-full high after reset", cur_test);
            chk_errors++;
        end
        end_test();

        begin_test("line bursts and stride");
        enable = 1'b1;
        start_frame(32'h0001_0000, 24);
        send_line();
        send_line();
        wait_drain();
        end_test();

        begin_test("padded tail word");
        start_frame(32'h0002_0000, 10);
        send_line();
        send_line();
        wait_drain();
        end_test();

        // stall until the FIFO nearly fills, then drain under random ready
        begin_test("back-pressure");
        start_frame(32'h0003_0000, 48);
        bp_mode = 2;
        send_line();
        wait_almost_full(1'b1);
        bp_mode = 1;
        wait_almost_full(1'b0);
        wait_drain();
        send_line();
        wait_drain();
        send_line();
        wait_drain();
        bp_mode = 0;
        end_test();

        begin_test("enable gate");
        enable = 1'b0;
        quiet  = 1'b1;
        start_frame(32'h0004_0000, 24);
        send_line();
        repeat (20) @(negedge clock);
        quiet  = 1'b0;
        enable = 1'b1;
        wait_drain();
        end_test();

        // second vsync restarts line 0 at the new base
        begin_test("new frame base");
        start_frame(32'h0005_0000, 24);
        send_line();
        send_line();
        wait_drain();
        start_frame(32'h0006_8000, 24);
        send_line();
        wait_drain();
        end_test();

        $display("tests: %0d, failing: %0d, errors: %0d", tests, fails, errors + chk_errors);
        if (fails == 0 && errors + chk_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: build.f
verilog/vdma_geom_pkg.sv
verilog/axi_wr_pkg.sv
verilog/pixel_packer.sv
verilog/line_fifo.sv
verilog/burst_scheduler.sv
verilog/axi_write_master.sv
verilog/vdma_write_top.sv
bench/vdma_write_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = vdma_write_tb
FILELIST  = build.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJDIR)
